//--- hdl/pktgen_macros.svh
// ********************
// widths, frame length limits and XGMII characters for the test-frame generator
// include wherever one of these constants is needed
// ********************
`ifndef PKTGEN_MACROS_SVH
`define PKTGEN_MACROS_SVH

// field and bus widths
`define PKT_DATA_W      64
`define PKT_CTRL_W      8
`define PKT_MOD_W       3
`define PKT_LEN_W       16
`define PKT_MAC_W       48
`define PKT_IP_W        32
`define PKT_PORT_W      16

// frame length range for the incrementing length mode
`define PKT_LEN_MIN     16'd64
`define PKT_LEN_MAX     16'd2048

// fixed header constants
`define PKT_TTL         8'd64
`define PKT_PROTO       8'd6
`define PKT_ETHERTYPE   16'h0800

// XGMII control and preamble bytes
`define XGMII_IDLE      8'h07
`define XGMII_START     8'hFB
`define XGMII_TERM      8'hFD
`define XGMII_PRE       8'h55
`define XGMII_SFD       8'hD5

`endif

//--- hdl/pktgen_pkg.sv
// ********************
// types shared by the frame generator blocks and the top level
// ********************
`default_nettype none

`include "pktgen_macros.svh"

package pktgen_pkg;

    // per-field value source
    typedef enum logic {
        MODE_FIXED = 1'b0,
        MODE_INC   = 1'b1
    } field_mode_t;

    // frame builder FSM
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SOP,
        ST_HDR,
        ST_VAL,
        ST_GAP
    } builder_state_t;

    // static generator configuration, base values then modes
    typedef struct packed {
        logic [`PKT_LEN_W-1:0]  len;
        logic [`PKT_MAC_W-1:0]  dmac;
        logic [`PKT_MAC_W-1:0]  smac;
        logic [`PKT_IP_W-1:0]   dip;
        logic [`PKT_IP_W-1:0]   sip;
        logic [`PKT_PORT_W-1:0] dp;
        logic [`PKT_PORT_W-1:0] sp;
        field_mode_t            len_mode;
        field_mode_t            dmac_mode;
        field_mode_t            smac_mode;
        field_mode_t            dip_mode;
        field_mode_t            sip_mode;
        field_mode_t            dp_mode;
        field_mode_t            sp_mode;
    } gen_cfg_t;

    // resolved header of one frame
    typedef struct packed {
        logic [`PKT_LEN_W-1:0]  len;
        logic [`PKT_MAC_W-1:0]  dmac;
        logic [`PKT_MAC_W-1:0]  smac;
        logic [`PKT_IP_W-1:0]   dip;
        logic [`PKT_IP_W-1:0]   sip;
        logic [`PKT_PORT_W-1:0] dp;
        logic [`PKT_PORT_W-1:0] sp;
    } frame_hdr_t;

    // one word of the frame stream, first wire byte in data[63:56]
    typedef struct packed {
        logic                   valid;
        logic                   sof;
        logic                   eof;
        logic [`PKT_DATA_W-1:0] data;
        // valid bytes in the eof word, 0 means 8
        logic [`PKT_MOD_W-1:0]  mod;
    } frame_word_t;

    // XGMII transmit, lane 0 in txd[7:0]
    typedef struct packed {
        logic [`PKT_DATA_W-1:0] txd;
        logic [`PKT_CTRL_W-1:0] txc;
    } xgmii_t;

endpackage

`default_nettype wire

//--- hdl/field_sequencer.sv
// ********************
// turns the static configuration into the header of the next frame
// each field is either its base value or base plus the frame index
// ********************
`timescale 1ns/1ns
`default_nettype none

`include "pktgen_macros.svh"

module field_sequencer (
    input  wire logic                 Clk,
    input  wire logic                 Reset,
    input  wire logic                 gen_en,
    input  wire pktgen_pkg::gen_cfg_t cfg,
    input  wire logic                 frame_start,
    output pktgen_pkg::frame_hdr_t    hdr
);

    import pktgen_pkg::*;

    // frame index since gen_en rose
    logic [31:0]           frame_idx;
    // length for the incrementing mode, wraps inside the legal range
    logic [`PKT_LEN_W-1:0] len_inc;
    frame_hdr_t            hdr_nxt;

    // base or base plus index, caller truncates to the field width
    function automatic logic [`PKT_MAC_W-1:0] resolve(
        input field_mode_t           mode,
        input logic [`PKT_MAC_W-1:0] base,
        input logic [31:0]           idx
    );
        logic [`PKT_MAC_W-1:0] value;
        if (mode == MODE_INC) begin
            value = base + {16'd0, idx};
        end else begin
            value = base;
        end
        return value;
    endfunction

    // ********************
    // frame index and incrementing length
    // ********************
    always_ff @(posedge Clk or posedge Reset) begin
        if (Reset) begin
            frame_idx <= '0;
            len_inc   <= `PKT_LEN_MIN;
        end else if (!gen_en) begin
            // restart the sequence from frame 0
            frame_idx <= '0;
            len_inc   <= `PKT_LEN_MIN;
        end else if (frame_start) begin
            frame_idx <= frame_idx + 32'd1;
            if (len_inc == `PKT_LEN_MAX) begin
                len_inc <= `PKT_LEN_MIN;
            end else begin
                len_inc <= len_inc + 16'd1;
            end
        end
    end

    // ********************
    // field resolution
    // ********************
    always_comb begin
        if (cfg.len_mode == MODE_INC) begin
            hdr_nxt.len = len_inc;
        end else begin
            hdr_nxt.len = cfg.len;
        end
        hdr_nxt.dmac = resolve(cfg.dmac_mode, cfg.dmac, frame_idx);
        hdr_nxt.smac = resolve(cfg.smac_mode, cfg.smac, frame_idx);
        hdr_nxt.dip  = `PKT_IP_W'(resolve(cfg.dip_mode, {16'd0, cfg.dip}, frame_idx));
        hdr_nxt.sip  = `PKT_IP_W'(resolve(cfg.sip_mode, {16'd0, cfg.sip}, frame_idx));
        hdr_nxt.dp   = `PKT_PORT_W'(resolve(cfg.dp_mode, {32'd0, cfg.dp}, frame_idx));
        hdr_nxt.sp   = `PKT_PORT_W'(resolve(cfg.sp_mode, {32'd0, cfg.sp}, frame_idx));
    end

    // registered next-frame header, the builder copies it on frame_start
    always_ff @(posedge Clk) begin
        hdr <= hdr_nxt;
    end

endmodule

`default_nettype wire

//--- hdl/frame_builder.sv
// ********************
// lays out each frame as 64-bit words with sof/eof/mod, counts frames
// against gen_num and times the idle gap between frames
// ********************
`timescale 1ns/1ns
`default_nettype none

`include "pktgen_macros.svh"

module frame_builder (
    input  wire logic                   Clk,
    input  wire logic                   Reset,
    input  wire logic                   gen_en,
    input  wire logic [31:0]            gen_num,
    input  wire logic [15:0]            idle_len,
    input  wire pktgen_pkg::frame_hdr_t hdr,
    output logic                        frame_start,
    output pktgen_pkg::frame_word_t     fw,
    output logic                        tx_done
);

    import pktgen_pkg::*;

    builder_state_t         state;
    // header and number of the frame in flight
    frame_hdr_t             hdr_q;
    logic [31:0]            frame_no;
    logic [31:0]            frame_cnt;
    logic [15:0]            word_idx;
    logic [15:0]            last_idx;
    logic [16:0]            gap_cnt;
    logic [16:0]            gap_end;
    logic                   start_ok;
    logic [`PKT_DATA_W-1:0] word_data;

    // gen_num of zero runs without limit
    assign start_ok    = gen_en && ((gen_num == 32'd0) || (frame_cnt < gen_num));
    assign frame_start = (state == ST_IDLE) && start_ok;
    assign tx_done     = (state == ST_IDLE) && !start_ok;

    // ceil(len/8) words, index of the last one
    assign last_idx = {3'b000, hdr_q.len[15:3]} + {15'd0, |hdr_q.len[2:0]} - 16'd1;
    assign gap_end  = {1'b0, idle_len} + 17'd1;

    always_ff @(posedge Clk) begin
        if (frame_start) begin
            hdr_q    <= hdr;
            frame_no <= frame_cnt;
        end
    end

    // ********************
    // word layout
    // ********************
    always_comb begin
        case (word_idx)
            16'd1: word_data = {hdr_q.smac[31:0], `PKT_ETHERTYPE, 8'h45, 8'h00};
            // total length, id, flags 2 / offset 0, ttl, protocol
            16'd2: word_data = {hdr_q.len - 16'd18, 16'h0000, 3'b010, 13'd0,
                                `PKT_TTL, `PKT_PROTO};
            // header checksum is sent as zero
            16'd3: word_data = {16'h0000, hdr_q.sip, hdr_q.dip[31:16]};
            16'd4: word_data = {hdr_q.dip[15:0], hdr_q.sp, hdr_q.dp, word_idx};
            // counting payload
            default: word_data = {frame_no, 16'd0, word_idx};
        endcase
    end

    // ********************
    // FSM
    // ********************
    always_ff @(posedge Clk or posedge Reset) begin
        if (Reset) begin
            state     <= ST_IDLE;
            fw        <= '0;
            word_idx  <= '0;
            gap_cnt   <= '0;
            frame_cnt <= '0;
        end else begin
            fw.valid <= 1'b0;
            fw.sof   <= 1'b0;
            fw.eof   <= 1'b0;
            fw.mod   <= '0;
            if (!gen_en) begin
                frame_cnt <= '0;
            end
            case (state)
                ST_IDLE: begin
                    if (start_ok) begin
                        // word 0 straight from the sequencer header
                        fw.valid  <= 1'b1;
                        fw.sof    <= 1'b1;
                        fw.data   <= {hdr.dmac, hdr.smac[47:32]};
                        word_idx  <= 16'd1;
                        frame_cnt <= frame_cnt + 32'd1;
                        state     <= ST_SOP;
                    end
                end
                ST_SOP: begin
                    fw.valid <= 1'b1;
                    fw.data  <= word_data;
                    word_idx <= word_idx + 16'd1;
                    state    <= ST_HDR;
                end
                ST_HDR: begin
                    fw.valid <= 1'b1;
                    fw.data  <= word_data;
                    word_idx <= word_idx + 16'd1;
                    if (word_idx == 16'd4) begin
                        state <= ST_VAL;
                    end
                end
                ST_VAL: begin
                    fw.valid <= 1'b1;
                    fw.data  <= word_data;
                    if (word_idx == last_idx) begin
                        fw.eof  <= 1'b1;
                        fw.mod  <= hdr_q.len[2:0];
                        gap_cnt <= '0;
                        state   <= ST_GAP;
                    end else begin
                        word_idx <= word_idx + 16'd1;
                    end
                end
                ST_GAP: begin
                    // first gap cycle still shows the eof word
                    if (gap_cnt == gap_end) begin
                        state <= ST_IDLE;
                    end else begin
                        gap_cnt <= gap_cnt + 17'd1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/xgmii_encoder.sv
// ********************
// XGMII transmit side: start/preamble word, byte to lane mapping,
// terminate and idle characters. Data leaves two cycles after arrival.
// ********************
`timescale 1ns/1ns
`default_nettype none

`include "pktgen_macros.svh"

module xgmii_encoder (
    input  wire logic                    Clk,
    input  wire logic                    Reset,
    input  wire pktgen_pkg::frame_word_t fw,
    output pktgen_pkg::xgmii_t           xgmii
);

    import pktgen_pkg::*;

    // one word delay so the start word can go out first
    frame_word_t            d1;
    // eof with mod 0 needs its own terminate word
    logic                   term_pend;
    logic [`PKT_DATA_W-1:0] lane_data;
    logic [`PKT_CTRL_W-1:0] lane_ctrl;

    // ********************
    // lane mapping
    // ********************
    always_comb begin
        lane_ctrl = '0;
        // first wire byte goes to lane 0
        for (int j = 0; j < 8; j++) begin
            lane_data[8*j +: 8] = d1.data[63-8*j -: 8];
        end
        if (d1.eof && (d1.mod != 3'd0)) begin
            lane_ctrl = 8'hFF << d1.mod;
            for (int j = 0; j < 8; j++) begin
                if (j == int'(d1.mod)) begin
                    lane_data[8*j +: 8] = `XGMII_TERM;
                end else if (j > int'(d1.mod)) begin
                    lane_data[8*j +: 8] = `XGMII_IDLE;
                end
            end
        end
    end

    // ********************
    // output register
    // ********************
    always_ff @(posedge Clk or posedge Reset) begin
        if (Reset) begin
            d1        <= '0;
            term_pend <= 1'b0;
            xgmii.txd <= {8{`XGMII_IDLE}};
            xgmii.txc <= 8'hFF;
        end else begin
            d1        <= fw;
            term_pend <= d1.valid && d1.eof && (d1.mod == 3'd0);
            if (d1.valid) begin
                xgmii.txd <= lane_data;
                xgmii.txc <= lane_ctrl;
            end else if (fw.valid && fw.sof) begin
                // start in lane 0, preamble, SFD in lane 7
                xgmii.txd <= {`XGMII_SFD, {6{`XGMII_PRE}}, `XGMII_START};
                xgmii.txc <= 8'h01;
            end else if (term_pend) begin
                xgmii.txd <= {{7{`XGMII_IDLE}}, `XGMII_TERM};
                xgmii.txc <= 8'hFF;
            end else begin
                xgmii.txd <= {8{`XGMII_IDLE}};
                xgmii.txc <= 8'hFF;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/xgmii_pktgen.sv
// ********************
// top level of the Ethernet/IPv4 test-frame generator
// config in, XGMII transmit out, tx_done high when no frame is pending
// ********************
`timescale 1ns/1ns
`default_nettype none

module xgmii_pktgen (
    input  wire logic                 Clk,
    input  wire logic                 Reset,
    input  wire logic                 gen_en,
    input  wire logic [31:0]          gen_num,
    input  wire logic [15:0]          idle_len,
    input  wire pktgen_pkg::gen_cfg_t cfg,
    output wire pktgen_pkg::xgmii_t   xgmii,
    output wire logic                 tx_done
);

    import pktgen_pkg::*;

    frame_hdr_t  hdr;
    frame_word_t fw;
    logic        frame_start;

    // next-frame header values
    field_sequencer u_field_sequencer (
        .Clk         (Clk),
        .Reset       (Reset),
        .gen_en      (gen_en),
        .cfg         (cfg),
        .frame_start (frame_start),
        .hdr         (hdr)
    );

    // frame word stream
    frame_builder u_frame_builder (
        .Clk         (Clk),
        .Reset       (Reset),
        .gen_en      (gen_en),
        .gen_num     (gen_num),
        .idle_len    (idle_len),
        .hdr         (hdr),
        .frame_start (frame_start),
        .fw          (fw),
        .tx_done     (tx_done)
    );

    // XGMII output
    xgmii_encoder u_xgmii_encoder (
        .Clk   (Clk),
        .Reset (Reset),
        .fw    (fw),
        .xgmii (xgmii)
    );

endmodule

`default_nettype wire

//--- verification/tb_frame_model.svh
// ********************
// reference model of the frame generator, included inside the testbench
// gives the header of frame k and each expected XGMII word of that frame
// ********************
`ifndef TB_FRAME_MODEL_SVH
`define TB_FRAME_MODEL_SVH

// resolved header fields of frame k since gen_en rose
function automatic frame_hdr_t expected_header(input gen_cfg_t c, input int unsigned k);
    frame_hdr_t  h;
    logic [15:0] span;
    span   = `PKT_LEN_MAX - `PKT_LEN_MIN + 16'd1;
    h.len  = (c.len_mode == MODE_INC) ? `PKT_LEN_MIN + 16'(k % 32'(span)) : c.len;
    h.dmac = (c.dmac_mode == MODE_INC) ? c.dmac + {16'd0, k} : c.dmac;
    h.smac = (c.smac_mode == MODE_INC) ? c.smac + {16'd0, k} : c.smac;
    h.dip  = (c.dip_mode == MODE_INC) ? c.dip + k : c.dip;
    h.sip  = (c.sip_mode == MODE_INC) ? c.sip + k : c.sip;
    h.dp   = (c.dp_mode == MODE_INC) ? c.dp + 16'(k) : c.dp;
    h.sp   = (c.sp_mode == MODE_INC) ? c.sp + 16'(k) : c.sp;
    return h;
endfunction

// byte p of the frame on the wire, 40 header bytes then the counting payload
function automatic logic [7:0] frame_byte(input frame_hdr_t h, input int unsigned k,
                                          input int unsigned p);
    logic [319:0] head;
    logic [63:0]  pay;
    logic [7:0]   b;
    head = {h.dmac, h.smac, `PKT_ETHERTYPE, 8'h45, 8'h00,
            h.len - 16'd18, 16'h0000, 16'h4000, `PKT_TTL, `PKT_PROTO,
            16'h0000, h.sip, h.dip, h.sp, h.dp, 16'd4};
    pay  = {k, p / 8};
    if (p < 40) begin
        b = head[319 - 8*p -: 8];
    end else begin
        b = pay[63 - 8*(p % 8) -: 8];
    end
    return b;
endfunction

// start word, data words and the terminate, which needs L+1 lanes
function automatic int unsigned xgmii_words(input frame_hdr_t h);
    return 1 + (32'(h.len) + 8) / 8;
endfunction

// word w of the frame as seen on XGMII, w = 0 is the start word
function automatic xgmii_t xgmii_word(input frame_hdr_t h, input int unsigned k,
                                      input int unsigned w);
    xgmii_t      x;
    int unsigned p;
    if (w == 0) begin
        x.txd = {`XGMII_SFD, {6{`XGMII_PRE}}, `XGMII_START};
        x.txc = 8'h01;
    end else begin
        for (int lane = 0; lane < 8; lane++) begin
            p = (w - 1) * 8 + lane;
            if (p < 32'(h.len)) begin
                x.txd[8*lane +: 8] = frame_byte(h, k, p);
                x.txc[lane]        = 1'b0;
            end else begin
                x.txd[8*lane +: 8] = (p == 32'(h.len)) ? `XGMII_TERM : `XGMII_IDLE;
                x.txc[lane]        = 1'b1;
            end
        end
    end
    return x;
endfunction

`endif

//--- verification/tb_xgmii_pktgen.sv
// ********************
// testbench of the XGMII test-frame generator
// drives config and enable, checks every XGMII word against the model
// ********************
`timescale 1ns/1ns
`default_nettype none

`include "pktgen_macros.svh"

module tb_xgmii_pktgen;

    import pktgen_pkg::*;

    `include "tb_frame_model.svh"

    localparam int CLK_PERIOD   = 10;
    // frames over all tests, cycles per frame with its gap, fixed waits
    localparam int FRAMES_MAX   = 17;
    localparam int FRAME_CYCLES = 22;
    localparam int WAIT_CYCLES  = 300;
    localparam int LIMIT_NS     = 2 * CLK_PERIOD * (FRAMES_MAX * FRAME_CYCLES + WAIT_CYCLES);

    logic        Clk;
    logic        Reset;
    logic        gen_en;
    logic [31:0] gen_num;
    logic [15:0] idle_len;
    gen_cfg_t    cfg;
    xgmii_t      xgmii;
    logic        tx_done;

    // monitor state
    // exp_k also counts the frames since the last restart
    int unsigned exp_k;
    int unsigned word_no;
    int unsigned word_cnt;
    int          idle_run;
    logic        in_frame;
    frame_hdr_t  exp_hdr;
    integer      seed;

    xgmii_pktgen u_xgmii_pktgen (
        .Clk      (Clk),
        .Reset    (Reset),
        .gen_en   (gen_en),
        .gen_num  (gen_num),
        .idle_len (idle_len),
        .cfg      (cfg),
        .xgmii    (xgmii),
        .tx_done  (tx_done)
    );

    initial begin
        Clk = 1'b0;
        forever #(CLK_PERIOD / 2) Clk = ~Clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic next_cycle();
        @(posedge Clk);
        #1;
    endtask

    task automatic check_word(input xgmii_t exp);
        assert (xgmii.txd === exp.txd) else report_failure($sformatf(
            "Error xgmii.txd: expected %h, actual %h (frame %0d word %0d)",
            exp.txd, xgmii.txd, exp_k, word_no));
        assert (xgmii.txc === exp.txc) else report_failure($sformatf(
            "Error xgmii.txc: expected %h, actual %h (frame %0d word %0d)",
            exp.txc, xgmii.txc, exp_k, word_no));
    endtask

    // fresh base values with every field fixed
    task automatic load_random_cfg(input logic [15:0] len);
        cfg      = '0;
        cfg.len  = len;
        cfg.dmac = {16'($random(seed)), 32'($random(seed))};
        cfg.smac = {16'($random(seed)), 32'($random(seed))};
        cfg.dip  = 32'($random(seed));
        cfg.sip  = 32'($random(seed));
        cfg.dp   = 16'($random(seed));
        cfg.sp   = 16'($random(seed));
    endtask

    // ********************
    // n frames with gen_num = n and nothing after them
    // ********************
    task automatic run_burst(input int unsigned n);
        repeat (3) next_cycle();
        exp_k   = 0;
        gen_num = n;
        gen_en  = 1'b1;
        do next_cycle(); while (!tx_done);
        repeat (20) next_cycle();
        assert (exp_k == n) else report_failure($sformatf(
            "Error frame count: expected %h, actual %h", n, exp_k));
        assert (tx_done === 1'b1) else report_failure($sformatf(
            "Error tx_done: expected %h, actual %h", 1'b1, tx_done));
        gen_en = 1'b0;
        repeat (3) next_cycle();
    endtask

    // ********************
    // compare process
    // ********************
    initial begin : monitor
        xgmii_t idle_word;
        idle_word.txd = {8{`XGMII_IDLE}};
        idle_word.txc = 8'hFF;
        exp_k    = 0;
        word_no  = 0;
        word_cnt = 0;
        idle_run = 0;
        in_frame = 1'b0;
        forever begin
            @(negedge Clk);
            if (in_frame) begin
                check_word(xgmii_word(exp_hdr, exp_k, word_no));
                word_no++;
                if (word_no == word_cnt) begin
                    in_frame = 1'b0;
                    idle_run = 0;
                    exp_k++;
                end
            end else if (xgmii.txc == 8'h01 && xgmii.txd[7:0] == `XGMII_START) begin
                if (exp_k != 0) begin
                    assert (idle_run >= int'(idle_len)) else
                        report_failure("gap between two frames is shorter than idle_len");
                end
                exp_hdr  = expected_header(cfg, exp_k);
                word_cnt = xgmii_words(exp_hdr);
                word_no  = 0;
                check_word(xgmii_word(exp_hdr, exp_k, 0));
                word_no  = 1;
                in_frame = 1'b1;
            end else begin
                check_word(idle_word);
                idle_run++;
            end
        end
    end

    initial begin : watchdog
        #(LIMIT_NS);
        report_failure("simulation timed out before all tests finished");
    end

    // ********************
    // stimulus
    // ********************
    initial begin
        seed     = 66267;
        Reset    = 1'b1;
        gen_en   = 1'b0;
        gen_num  = '0;
        idle_len = '0;
        cfg      = '0;
        repeat (3) @(posedge Clk);
        #1;
        Reset = 1'b0;

        // idle after reset
        repeat (5) begin
            next_cycle();
            assert (tx_done === 1'b1) else report_failure($sformatf(
                "Error tx_done: expected %h, actual %h", 1'b1, tx_done));
        end

        // all fixed with the terminate inside the last word and as its own word
        idle_len = 16'd3;
        load_random_cfg(16'd64);
        run_burst(2);
        load_random_cfg(16'd67);
        run_burst(2);
        load_random_cfg(16'd72);
        run_burst(2);

        // incrementing length, dmac, dip and sp
        // sp wraps through zero
        idle_len      = 16'd2;
        load_random_cfg(16'd64);
        cfg.sp        = 16'hFFFE;
        cfg.len_mode  = MODE_INC;
        cfg.dmac_mode = MODE_INC;
        cfg.dip_mode  = MODE_INC;
        cfg.sp_mode   = MODE_INC;
        run_burst(4);

        // gen_num limit with a longer gap
        idle_len = 16'd6;
        load_random_cfg(16'd80);
        run_burst(3);

        // free run stopped in the gap after two frames
        // restart from k = 0 with length, smac, sip and dp incrementing
        idle_len      = 16'd4;
        gen_num       = 32'd0;
        load_random_cfg(16'd80);
        cfg.len_mode  = MODE_INC;
        cfg.smac_mode = MODE_INC;
        cfg.sip_mode  = MODE_INC;
        cfg.dp_mode   = MODE_INC;
        exp_k         = 0;
        repeat (3) next_cycle();
        gen_en = 1'b1;
        do next_cycle(); while (!(exp_k == 2 && !in_frame));
        gen_en = 1'b0;
        do next_cycle(); while (!tx_done);
        repeat (5) next_cycle();
        assert (exp_k == 2) else report_failure($sformatf(
            "Error frame count: expected %h, actual %h", 2, exp_k));
        run_burst(2);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+hdl
+incdir+verification
hdl/pktgen_pkg.sv
hdl/field_sequencer.sv
hdl/frame_builder.sv
hdl/xgmii_encoder.sv
hdl/xgmii_pktgen.sv
verification/tb_xgmii_pktgen.sv

//--- Makefile
# Verilator build and run of the XGMII frame generator testbench

TOP := tb_xgmii_pktgen

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f vlog.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
